//--- hdl/audio_lpf_top.sv
`timescale 1ns/100ps
`default_nettype none

module audio_lpf_top #(
	parameter int sample_width = 24,
	parameter int in_depth = 16,
	parameter int out_depth = 8
) (
	input wire clk,
	input wire reset_n,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [1:0] adr,
	input wire [lpf_pkg::WB_DATA_W-1:0] dat_w,
	output logic [lpf_pkg::WB_DATA_W-1:0] dat_r,
	output logic ack
);
	import lpf_pkg::*;

	// input fifo holds raw samples, output fifo holds {mode, result}
	typedef logic signed [sample_width-1:0] sample_t;
	typedef logic [sample_width+2:0] tagged_t;

	logic in_push;
	sample_t in_push_data;
	logic in_pop;
	sample_t in_pop_data;
	logic [CNT_W-1:0] in_count;
	logic out_push;
	tagged_t out_push_data;
	logic out_pop;
	tagged_t out_pop_data;
	logic [CNT_W-1:0] out_count;
	filt_mode_t mode;

	wb_sample_port #(
		.sample_width(sample_width),
		.in_depth(in_depth)
	) port_i (
		.clk(clk),
		.reset_n(reset_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.in_push(in_push),
		.in_push_data(in_push_data),
		.in_count(in_count),
		.out_pop(out_pop),
		.out_pop_data(out_pop_data),
		.out_count(out_count),
		.mode(mode)
	);

	sample_fifo #(
		.depth(in_depth),
		.payload_t(sample_t)
	) in_fifo_i (
		.clk(clk),
		.reset_n(reset_n),
		.push(in_push),
		.push_data(in_push_data),
		.pop(in_pop),
		.pop_data(in_pop_data),
		.count(in_count)
	);

	lpf_bank #(
		.sample_width(sample_width),
		.out_depth(out_depth)
	) bank_i (
		.clk(clk),
		.reset_n(reset_n),
		.mode(mode),
		.in_count(in_count),
		.in_data(in_pop_data),
		.in_pop(in_pop),
		.out_count(out_count),
		.out_push(out_push),
		.out_data(out_push_data)
	);

	sample_fifo #(
		.depth(out_depth),
		.payload_t(tagged_t)
	) out_fifo_i (
		.clk(clk),
		.reset_n(reset_n),
		.push(out_push),
		.push_data(out_push_data),
		.pop(out_pop),
		.pop_data(out_pop_data),
		.count(out_count)
	);

endmodule

`default_nettype wire

//--- hdl/lpf_bank.sv
`timescale 1ns/100ps
`default_nettype none

module lpf_bank #(
	parameter int sample_width = 24,
	parameter int out_depth = 8
) (
	input wire clk,
	input wire reset_n,
	input wire lpf_pkg::filt_mode_t mode,
	input wire [lpf_pkg::CNT_W-1:0] in_count,
	input wire signed [sample_width-1:0] in_data,
	output logic in_pop,
	input wire [lpf_pkg::CNT_W-1:0] out_count,
	output logic out_push,
	output logic [sample_width+2:0] out_data
);
	import lpf_pkg::*;

	// arithmetic shift per tap, tap 0 is the newest sample
	localparam int unsigned tap_shift [8][TAP_COUNT] = '{
		'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{2, 2, 2, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
		'{3, 3, 3, 3, 3, 3, 3, 3, 0, 0, 0, 0, 0, 0, 0, 0},
		'{4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4, 4},
		'{6, 6, 5, 4, 3, 2, 2, 2, 0, 0, 0, 0, 0, 0, 0, 0},
		'{8, 8, 7, 6, 5, 4, 3, 2, 2, 0, 0, 0, 0, 0, 0, 0},
		'{11, 11, 10, 9, 8, 7, 6, 5, 4, 3, 2, 3, 3, 3, 3, 0}
	};

	// taps that enter the sum, bit n is tap n
	localparam logic [TAP_COUNT-1:0] tap_used [8] = '{
		16'h0001,
		16'h0003,
		16'h000f,
		16'h00ff,
		16'hffff,
		16'h00ff,
		16'h01ff,
		16'h7fff
	};

	logic signed [sample_width-1:0] del [TAP_COUNT];
	logic s1_valid;
	filt_mode_t s1_mode;
	logic [1:0] in_flight;
	logic [CNT_W:0] out_pending;
	logic signed [sample_width-1:0] acc;

	// results still in the pipe, not yet counted by the output fifo
	assign in_flight = {1'b0, s1_valid} + {1'b0, out_push};
	assign out_pending = {1'b0, out_count} + {{(CNT_W-1){1'b0}}, in_flight};

	// only pop when the result is sure to find room downstream
	assign in_pop = (in_count != '0) && (out_pending < (CNT_W+1)'(out_depth));

	// stage 1: delay line shift on pop
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int t = 0; t < TAP_COUNT; t++) begin
				del[t] <= '0;
			end
		end else if (in_pop) begin
			del[0] <= in_data;
			for (int t = 1; t < TAP_COUNT; t++) begin
				del[t] <= del[t-1];
			end
		end
	end

	// mode follows the sample it was latched with
	always_ff @(posedge clk) begin
		if (in_pop) begin
			s1_mode <= mode;
		end
	end

	// shift-and-add over the stage 1 snapshot, wraps at sample_width
	always_comb begin
		acc = '0;
		for (int t = 0; t < TAP_COUNT; t++) begin
			if (tap_used[s1_mode][t]) begin
				acc = acc + (del[t] >>> tap_shift[s1_mode][t]);
			end
		end
	end

	// stage 2: tagged result
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			out_data <= {s1_mode, acc};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s1_valid <= 1'b0;
			out_push <= 1'b0;
		end else begin
			s1_valid <= in_pop;
			out_push <= s1_valid;
		end
	end

endmodule

`default_nettype wire

//--- hdl/lpf_pkg.sv
`default_nettype none

package lpf_pkg;

	// wishbone data bus width
	localparam int WB_DATA_W = 32;

	// fifo occupancy count width, one status byte per fifo
	localparam int CNT_W = 8;

	// delay line length of the filter bank
	localparam int TAP_COUNT = 16;

	// word addresses of the register map
	localparam logic [1:0] ADDR_SAMPLE = 2'd0;
	localparam logic [1:0] ADDR_MODE = 2'd1;
	localparam logic [1:0] ADDR_RESULT = 2'd2;
	localparam logic [1:0] ADDR_STATUS = 2'd3;

	// low-pass modes
	typedef enum logic [2:0] {
		// newest tap only
		mode_pass = 3'd0,
		// running averages, equal weights
		mode_avg2 = 3'd1,
		mode_avg4 = 3'd2,
		mode_avg8 = 3'd3,
		mode_avg16 = 3'd4,
		// tapered kernels, weight rises toward older taps
		mode_exp_a = 3'd5,
		mode_exp_b = 3'd6,
		mode_exp_c = 3'd7
	} filt_mode_t;

endpackage

`default_nettype wire

//--- hdl/sample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sample_fifo #(
	parameter int depth = 16,
	parameter type payload_t = logic [23:0]
) (
	input wire clk,
	input wire reset_n,
	input wire push,
	input wire payload_t push_data,
	input wire pop,
	output payload_t pop_data,
	output logic [lpf_pkg::CNT_W-1:0] count
);
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_next;
	logic [ptr_w-1:0] rd_next;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = count == $bits(count)'(depth);
	assign empty = count == '0;
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// pointers wrap at depth, which need not be a power of two
	assign wr_next = (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
	assign rd_next = (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;

	// first word fall through
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_next;
			end
			if (do_pop) begin
				rd_ptr <= rd_next;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/wb_sample_port.sv
`timescale 1ns/100ps
`default_nettype none

module wb_sample_port #(
	parameter int sample_width = 24,
	parameter int in_depth = 16
) (
	input wire clk,
	input wire reset_n,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [1:0] adr,
	input wire [lpf_pkg::WB_DATA_W-1:0] dat_w,
	output logic [lpf_pkg::WB_DATA_W-1:0] dat_r,
	output logic ack,
	output logic in_push,
	output logic [sample_width-1:0] in_push_data,
	input wire [lpf_pkg::CNT_W-1:0] in_count,
	output logic out_pop,
	input wire [sample_width+2:0] out_pop_data,
	input wire [lpf_pkg::CNT_W-1:0] out_count,
	output lpf_pkg::filt_mode_t mode
);
	import lpf_pkg::*;

	// result word keeps the sample below this bit, the tag above
	localparam int res_w = 28;

	logic req;
	logic wr_sample;
	logic wr_mode;
	logic rd_result;
	logic in_full;
	logic out_empty;
	logic go;
	logic signed [sample_width-1:0] res_sample;
	logic signed [res_w-1:0] res_ext;
	logic [WB_DATA_W-1:0] rd_word;

	// new request only while no ack is out, so a held stb is not seen twice
	assign req = cyc && stb && !ack;

	assign wr_sample = req && we && (adr == ADDR_SAMPLE);
	assign wr_mode = req && we && (adr == ADDR_MODE);
	assign rd_result = req && !we && (adr == ADDR_RESULT);

	assign in_full = in_count >= CNT_W'(in_depth);
	assign out_empty = out_count == '0;

	// wait states on full input or empty output fifo
	assign go = req && !(wr_sample && in_full) && !(rd_result && out_empty);

	assign res_sample = out_pop_data[sample_width-1:0];
	// sign extension up to the tag field
	assign res_ext = res_sample;

	always_comb begin
		case (adr)
			ADDR_RESULT: rd_word = {1'b0, out_pop_data[sample_width+2 -: 3], res_ext};
			ADDR_STATUS: rd_word = {{(WB_DATA_W-2*CNT_W){1'b0}}, out_count, in_count};
			ADDR_MODE: rd_word = WB_DATA_W'(mode);
			default: rd_word = '0;
		endcase
	end

	// single-cycle strobes and the mode register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ack <= 1'b0;
			in_push <= 1'b0;
			out_pop <= 1'b0;
			mode <= mode_pass;
		end else begin
			ack <= go;
			in_push <= go && wr_sample;
			out_pop <= go && rd_result;
			if (go && wr_mode) begin
				mode <= filt_mode_t'(dat_w[2:0]);
			end
		end
	end

	// data registers, valid alongside the strobes
	always_ff @(posedge clk) begin
		if (go && wr_sample) begin
			in_push_data <= dat_w[sample_width-1:0];
		end
		if (go && !we) begin
			dat_r <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_audio_lpf \
	--Mdir obj_dir -o sim_audio_lpf &&
{ ./obj_dir/sim_audio_lpf +verilator+error+limit+1000 > sim.log 2>&1 || true; } &&
grep -q "^all tests passed$" sim.log &&
echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

//--- testbench/lpf_props.sv
`timescale 1ns/100ps
`default_nettype none

module lpf_props #(
	parameter int in_depth = 16,
	parameter int out_depth = 8
) (
	input wire clk,
	input wire reset_n,
	input wire cyc,
	input wire stb,
	input wire ack,
	input wire in_push,
	input wire in_pop,
	input wire [lpf_pkg::CNT_W-1:0] in_count,
	input wire out_push,
	input wire out_pop,
	input wire [lpf_pkg::CNT_W-1:0] out_count
);
	// failed properties, summed into the testbench result
	int fail_count = 0;

	ack_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		ack |=> !ack)
		else begin
			fail_count++;
			$error("ack stayed high for two cycles in a row");
		end

	// ack only inside an active bus cycle
	ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		ack |-> (cyc && stb))
		else begin
			fail_count++;
			$error("ack raised without cyc and stb");
		end

	in_fifo_safe: assert property (@(posedge clk) disable iff (!reset_n)
		!(in_push && in_count >= in_depth) && !(in_pop && in_count == '0))
		else begin
			fail_count++;
			$error("input fifo pushed while full or popped while empty");
		end

	out_fifo_safe: assert property (@(posedge clk) disable iff (!reset_n)
		!(out_push && out_count >= out_depth) && !(out_pop && out_count == '0))
		else begin
			fail_count++;
			$error("output fifo pushed while full or popped while empty");
		end

endmodule

bind audio_lpf_top lpf_props #(.in_depth(in_depth), .out_depth(out_depth))
	props_i (.*);

`default_nettype wire

//--- testbench/tb_audio_lpf.sv
`timescale 1ns/100ps
`default_nettype none

module tb_audio_lpf;
	import lpf_pkg::*;

	localparam int sample_w = 24;
	localparam int max_cycles = 20000;
	localparam logic [sample_w-1:0] most_neg = 24'h800000;
	localparam logic [sample_w-1:0] most_pos = 24'h7fffff;

	logic clk;
	logic reset_n;
	logic cyc;
	logic stb;
	logic we;
	logic [1:0] adr;
	logic [WB_DATA_W-1:0] dat_w;
	wire [WB_DATA_W-1:0] dat_r;
	wire ack;
	logic signed [sample_w-1:0] model_del [TAP_COUNT];
	logic [2:0] model_mode;
	logic [31:0] expect_q [$];
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;

	audio_lpf_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// shift for one tap of one mode, -1 when the tap is not summed
	function automatic int tap_shift(input int m, input int t);
		int kern_a [8] = '{6, 6, 5, 4, 3, 2, 2, 2};
		int kern_b [9] = '{8, 8, 7, 6, 5, 4, 3, 2, 2};
		int kern_c [15] = '{11, 11, 10, 9, 8, 7, 6, 5, 4, 3, 2, 3, 3, 3, 3};
		if (m <= 4) begin
			return (t < (1 << m)) ? m : -1;
		end else if (m == 5) begin
			return (t < 8) ? kern_a[t] : -1;
		end else if (m == 6) begin
			return (t < 9) ? kern_b[t] : -1;
		end
		return (t < 15) ? kern_c[t] : -1;
	endfunction

	// software delay line, queues the tagged word each sample should produce
	task automatic model_push(input logic signed [sample_w-1:0] s);
		logic signed [sample_w-1:0] acc;
		logic signed [27:0] wide;
		int sh;
		for (int t = TAP_COUNT - 1; t > 0; t--) begin
			model_del[t] = model_del[t-1];
		end
		model_del[0] = s;
		acc = '0;
		for (int t = 0; t < TAP_COUNT; t++) begin
			sh = tap_shift(model_mode, t);
			if (sh >= 0) begin
				acc = acc + (model_del[t] >>> sh);
			end
		end
		wide = acc;
		expect_q.push_back({1'b0, model_mode, wide});
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// one classic cycle, held until ack
	task automatic bus_cycle(input logic write, input logic [1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr;
		dat_w <= wdata;
		@(posedge clk);
		while (!ack) begin
			@(posedge clk);
		end
		rdata = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic write_sample(input logic [sample_w-1:0] s);
		logic [31:0] unused;
		bus_cycle(1'b1, ADDR_SAMPLE, {{(32-sample_w){s[sample_w-1]}}, s}, unused);
		model_push(s);
	endtask

	task automatic set_mode(input filt_mode_t m);
		logic [31:0] unused;
		bus_cycle(1'b1, ADDR_MODE, 32'(m), unused);
		model_mode = m;
	endtask

	task automatic read_result(input string name, output logic [31:0] word);
		bus_cycle(1'b0, ADDR_RESULT, '0, word);
		check_word(name, expect_q.pop_front(), word);
	endtask

	task automatic drain(input string name);
		logic [31:0] word;
		while (expect_q.size() > 0) begin
			read_result(name, word);
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] expected);
		logic [31:0] word;
		bus_cycle(1'b0, ADDR_STATUS, '0, word);
		check_word(name, expected, word);
	endtask

	task automatic stream_random(input string name, input int n);
		for (int i = 0; i < n; i++) begin
			write_sample(sample_w'($urandom()));
			if (i % 8 == 7) begin
				drain(name);
			end
		end
		drain(name);
	endtask

	// request held against full fifos, then withdrawn
	task automatic hold_stalled_write(input int cycles);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= ADDR_SAMPLE;
		dat_w <= 32'h0012_3456;
		repeat (cycles) begin
			@(posedge clk);
			assert (!ack) else begin
				other_errors++;
				$display("backpressure: a sample write was acked with both fifos full");
			end
		end
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	initial begin
		logic [31:0] word;
		void'($urandom(32'hc7c3));
		reset_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		model_mode = 3'd0;
		foreach (model_del[t]) begin
			model_del[t] = '0;
		end
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		check_status("reset_status", 32'h0);
		write_sample(24'ha53c81);
		read_result("reset_pass", word);
		check_word("reset_pass_word", 32'h0fa53c81, word);

		for (int m = 1; m <= 7; m++) begin
			set_mode(filt_mode_t'(m));
			stream_random($sformatf("mode%0d_stream", m), 40);
		end

		// delay line history runs on across the mode writes
		set_mode(mode_avg4);
		stream_random("change_avg4", 5);
		set_mode(mode_exp_b);
		stream_random("change_exp_b", 5);
		set_mode(mode_pass);
		stream_random("change_pass", 3);
		set_mode(mode_avg16);
		stream_random("change_avg16", 4);

		// fill both fifos, 16 in and 8 out
		set_mode(mode_avg8);
		repeat (24) write_sample(sample_w'($urandom()));
		repeat (8) @(posedge clk);
		check_status("bp_settled", 32'h0000_0810);
		hold_stalled_write(16);
		check_status("bp_held", 32'h0000_0810);
		drain("bp_readback");
		stream_random("bp_tail", 6);

		set_mode(mode_avg16);
		repeat (16) write_sample(most_neg);
		drain("extreme_neg");
		repeat (16) write_sample(most_pos);
		drain("extreme_pos");
		set_mode(mode_exp_c);
		for (int i = 0; i < 16; i++) begin
			write_sample(i[0] ? most_pos : most_neg);
		end
		drain("extreme_mixed");

		// both fifos empty once every result is read
		repeat (4) @(posedge clk);
		check_status("end_status", 32'h0);
		$display("errors: value %0d, property %0d, other %0d",
			value_errors, dut_i.props_i.fail_count, other_errors);
		if (value_errors + other_errors + dut_i.props_i.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		while (cycle_count < max_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", max_cycles);
		$display("errors: value %0d, property %0d, other %0d",
			value_errors, dut_i.props_i.fail_count, other_errors + 1);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/lpf_pkg.sv
hdl/wb_sample_port.sv
hdl/sample_fifo.sv
hdl/lpf_bank.sv
hdl/audio_lpf_top.sv
testbench/lpf_props.sv
testbench/tb_audio_lpf.sv
